// ==== include/gb_config.svh ====
/*
 * Sizes and constants for the system-bus core.
 * IRAM width sets the echo alias of c000-fdff; HRAM holds 2**AW - 1 bytes
 * because ffff is taken by IE. DIV period must be a power of two.
 */
`ifndef GB_CONFIG_SVH
`define GB_CONFIG_SVH

// --------------------
// memories
`define GB_IRAM_AW 13 // 8 KB internal ram
`define GB_HRAM_AW 7  // 127 bytes high ram, top entry unused

// --------------------
// timer
`define GB_DIV_PERIOD 256 // clocks per DIV step

// --------------------
// boot
`define GB_FAST_BOOT_FLAG 8'h42 // seen at ff50 by the boot ROM on fast boot

`endif

// ==== logic/gb_map_pkg.sv ====
/*
 * Memory map types for the CPU bus.
 * Only the regions this core serves are listed; video, audio and OAM
 * ranges fall into unmapped and read as ff.
 */
package gb_map_pkg;

	// region hit by the current cpu address
	typedef enum logic [3:0] {
		rom,      // 0000-7fff cartridge rom, boot overlay at the bottom
		cram,     // a000-bfff cartridge ram
		vram,     // 8000-9fff, not implemented here
		iram,     // c000-fdff incl. echo
		hram,     // ff80-fffe
		joy,
		timer,
		irq_en,
		irq_flag,
		boot_ctl,
		unmapped
	} region_e;

	// --------------------
	// register addresses
	localparam logic [15:0] joy_addr      = 16'hff00;
	localparam logic [15:0] timer_base    = 16'hff04; // DIV, TIMA, TMA, TAC
	localparam logic [15:0] if_addr       = 16'hff0f;
	localparam logic [15:0] boot_ctl_addr = 16'hff50;
	localparam logic [15:0] ie_addr       = 16'hffff;

endpackage

// ==== logic/gb_periph_pkg.sv ====
/*
 * Peripheral types: interrupt sources and timer rate select.
 * Source index is also the priority, lowest index wins.
 */
package gb_periph_pkg;

	localparam int unsigned irq_num = 5; // width of IE and IF

	// interrupt source, bit position in IE/IF
	typedef enum logic [2:0] {
		vblank = 3'd0, // only settable by a cpu write here
		lcd    = 3'd1, // same
		timer  = 3'd2,
		serial = 3'd3, // same
		joypad = 3'd4
	} irq_src_e;

	// TAC bits 1:0
	typedef enum logic [1:0] {
		div1024 = 2'd0,
		div16   = 2'd1,
		div64   = 2'd2,
		div256  = 2'd3
	} timer_clk_e;

endpackage

// ==== logic/gb_bus_if.sv ====
/*
 * Internal CPU bus, driven by the decoder only.
 * rd and wr are single-cycle strobes, there is no handshake.
 */
`timescale 1ns/1ps

interface gb_bus_if;

	logic [15:0]         addr;
	logic [7:0]          wdata;
	logic                rd;
	logic                wr;
	gb_map_pkg::region_e region; // decoded once, in the decoder

	// decoder side
	modport dec (output addr, output wdata, output rd, output wr, output region);

	// peripherals and rams, listen only
	modport per (input addr, input wdata, input rd, input wr, input region);

endinterface

// ==== logic/gb_bus_decode.sv ====
/*
 * Address decode and registered read path.
 * cpu_rdata is valid one cycle after rd or irq_ack and holds until the next one.
 * RAM data is already registered in the RAM, so it bypasses rdata_q.
 * Boot overlay covers 0000-00ff until a write with bit 0 set hits ff50.
 */
`timescale 1ns/1ps
`include "gb_config.svh"

module gb_bus_decode (
	input  logic        clk,
	input  logic        reset,
	input  logic        fast_boot,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_rd,
	input  logic        cpu_wr,
	input  logic        irq_ack,
	gb_bus_if.dec       bus,
	input  logic [7:0]  joy_rdata,
	input  logic [7:0]  timer_rdata,
	input  logic [7:0]  irq_rdata,
	input  logic [7:0]  ram_rdata,
	input  logic [7:0]  cart_data,
	input  logic [7:0]  boot_rom_data,
	input  logic [7:0]  irq_vec,
	output logic [7:0]  cpu_rdata,
	output logic        cart_rd,
	output logic        cart_wr
);

	gb_map_pkg::region_e region;
	logic       boot_on;   // boot rom overlay active
	logic       boot_win;  // address inside the overlay
	logic       ram_hit;
	logic       cart_hit;
	logic [7:0] rd_mux;
	logic [7:0] rdata_q;
	logic       ram_sel_q; // last read came from a ram

	// --------------------
	// region decode
	always_comb begin
		region = gb_map_pkg::unmapped;
		if (!cpu_addr[15])
			region = gb_map_pkg::rom;
		else if (cpu_addr[15:13] == 3'b100)
			region = gb_map_pkg::vram;
		else if (cpu_addr[15:13] == 3'b101)
			region = gb_map_pkg::cram;
		else if (cpu_addr < 16'hfe00)
			region = gb_map_pkg::iram;                // c000 up to the end of echo
		else if (cpu_addr == gb_map_pkg::ie_addr)
			region = gb_map_pkg::irq_en;              // must win over hram
		else if (cpu_addr[15:7] == 9'h1ff)
			region = gb_map_pkg::hram;
		else if (cpu_addr == gb_map_pkg::joy_addr)
			region = gb_map_pkg::joy;
		else if (cpu_addr[15:2] == gb_map_pkg::timer_base[15:2])
			region = gb_map_pkg::timer;
		else if (cpu_addr == gb_map_pkg::if_addr)
			region = gb_map_pkg::irq_flag;
		else if (cpu_addr == gb_map_pkg::boot_ctl_addr)
			region = gb_map_pkg::boot_ctl;
	end

	assign bus.addr   = cpu_addr;
	assign bus.wdata  = cpu_wdata;
	assign bus.rd     = cpu_rd;
	assign bus.wr     = cpu_wr;
	assign bus.region = region;

	assign boot_win = boot_on && (cpu_addr[15:8] == 8'h00);
	assign ram_hit  = (region == gb_map_pkg::iram) || (region == gb_map_pkg::hram);
	assign cart_hit = (region == gb_map_pkg::rom) || (region == gb_map_pkg::cram);

	// cartridge sees cpu_addr directly, only the strobes come from here
	assign cart_rd = cpu_rd && cart_hit && !boot_win;
	assign cart_wr = cpu_wr && cart_hit; // writes go to the mbc even under the overlay

	// --------------------
	// read mux
	always_comb begin
		rd_mux = 8'hff; // vram, unmapped, and ram (taken from the ram port)
		if (irq_ack)
			rd_mux = irq_vec;
		else begin
			case (region)
				gb_map_pkg::rom:      rd_mux = boot_win ? boot_rom_data : cart_data;
				gb_map_pkg::cram:     rd_mux = cart_data;
				gb_map_pkg::joy:      rd_mux = joy_rdata;
				gb_map_pkg::timer:    rd_mux = timer_rdata;
				gb_map_pkg::irq_en,
				gb_map_pkg::irq_flag: rd_mux = irq_rdata;
				gb_map_pkg::boot_ctl: begin
					if (fast_boot && boot_on)
						rd_mux = `GB_FAST_BOOT_FLAG;
				end
				default:              rd_mux = 8'hff;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rdata_q   <= 8'hff; // bus idles high
			ram_sel_q <= 1'b0;
			boot_on   <= 1'b1;
		end else begin
			if (cpu_rd || irq_ack) begin
				rdata_q   <= rd_mux;
				ram_sel_q <= cpu_rd && !irq_ack && ram_hit;
			end
			if (cpu_wr && (region == gb_map_pkg::boot_ctl) && cpu_wdata[0])
				boot_on <= 1'b0; // one way, only reset brings it back
		end
	end

	// ram output holds until its next read, same latency as rdata_q
	assign cpu_rdata = ram_sel_q ? ram_rdata : rdata_q;

	// --------------------
	// cpu strobe rules
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(cpu_rd && cpu_wr));
	a_ack_no_rd:  assert property (@(posedge clk) disable iff (reset) !(irq_ack && cpu_rd));

endmodule

// ==== logic/gb_irq_ctrl.sv ====
/*
 * Interrupt enable and flag registers with priority acknowledge.
 * Vector is 40 + 8 * lowest pending enabled source, ff when none.
 * A cpu write to IF wins over an event pulse in the same cycle.
 */
`timescale 1ns/1ps

module gb_irq_ctrl (
	input  logic       clk,
	input  logic       reset,
	gb_bus_if.per      bus,
	input  logic       irq_ack,
	input  logic       timer_irq,
	input  logic       joy_irq,
	output logic       irq,
	output logic [7:0] irq_vec,
	output logic [7:0] rdata
);

	localparam int unsigned n = gb_periph_pkg::irq_num;

	logic [n-1:0] ie_q;
	logic [n-1:0] if_q;
	logic [n-1:0] pending;
	logic [2:0]   src_idx;  // highest priority pending source
	logic         src_hit;
	logic         ie_wr;
	logic         if_wr;

	assign ie_wr = bus.wr && (bus.region == gb_map_pkg::irq_en);
	assign if_wr = bus.wr && (bus.region == gb_map_pkg::irq_flag);

	assign pending = ie_q & if_q;
	assign irq     = |pending; // level, cpu samples it

	// lowest index wins, so scan downwards and keep the last hit
	always_comb begin
		src_idx = 3'd0;
		src_hit = 1'b0;
		for (int i = n - 1; i >= 0; i--) begin
			if (pending[i]) begin
				src_idx = 3'(i);
				src_hit = 1'b1;
			end
		end
	end

	assign irq_vec = src_hit ? (8'h40 + {2'b00, src_idx, 3'b000}) : 8'hff;

	always_ff @(posedge clk) begin
		if (reset) begin
			ie_q <= '0;
			if_q <= '0;
		end else begin
			// event pulses, one cycle each
			if (timer_irq)
				if_q[gb_periph_pkg::timer] <= 1'b1;
			if (joy_irq)
				if_q[gb_periph_pkg::joypad] <= 1'b1;
			if (irq_ack && src_hit)
				if_q[src_idx] <= 1'b0; // clear only the serviced one
			if (if_wr)
				if_q <= bus.wdata[n-1:0]; // last, so cpu write wins
			if (ie_wr)
				ie_q <= bus.wdata[n-1:0];
		end
	end

	// decoder only picks this up for irq_en / irq_flag
	assign rdata = (bus.region == gb_map_pkg::irq_en) ? {3'b000, ie_q} : {3'b000, if_q};

	// cpu must not acknowledge without a request
	a_ack_needs_irq: assert property (@(posedge clk) disable iff (reset) irq_ack |-> irq);

endmodule

// ==== logic/gb_timer.sv ====
/*
 * DIV, TIMA, TMA and TAC at ff04-ff07.
 * TIMA prescaler restarts when TAC bit 2 is cleared, it is not tied to DIV.
 * irq is a one-cycle pulse on TIMA overflow.
 */
`timescale 1ns/1ps
`include "gb_config.svh"

module gb_timer (
	input  logic       clk,
	input  logic       reset,
	gb_bus_if.per      bus,
	output logic       irq,
	output logic [7:0] rdata
);

	localparam int div_w = $clog2(`GB_DIV_PERIOD);

	logic [div_w-1:0] div_pre;  // clocks within one DIV step
	logic [7:0]       div_q;
	logic [7:0]       tima;
	logic [7:0]       tma;
	logic [2:0]       tac;      // bit 2 enable, 1:0 rate
	logic [9:0]       tima_pre;
	logic             tima_tick;
	logic             sel;

	assign sel = bus.wr && (bus.region == gb_map_pkg::timer);

	// tick on the last clock of the selected period
	always_comb begin
		tima_tick = 1'b0;
		case (gb_periph_pkg::timer_clk_e'(tac[1:0]))
			gb_periph_pkg::div1024: tima_tick = &tima_pre[9:0];
			gb_periph_pkg::div16:   tima_tick = &tima_pre[3:0];
			gb_periph_pkg::div64:   tima_tick = &tima_pre[5:0];
			gb_periph_pkg::div256:  tima_tick = &tima_pre[7:0];
		endcase
		tima_tick = tima_tick && tac[2];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			div_pre  <= '0;
			div_q    <= '0;
			tima     <= '0;
			tma      <= '0;
			tac      <= '0;
			tima_pre <= '0;
			irq      <= 1'b0;
		end else begin
			irq <= 1'b0;

			// DIV, any write clears it
			if (sel && (bus.addr[1:0] == 2'd0)) begin
				div_pre <= '0;
				div_q   <= '0;
			end else if (div_pre == div_w'(`GB_DIV_PERIOD - 1)) begin
				div_pre <= '0;
				div_q   <= div_q + 8'd1;
			end else
				div_pre <= div_pre + 1'b1;

			tima_pre <= tac[2] ? tima_pre + 10'd1 : 10'd0;

			if (sel && (bus.addr[1:0] == 2'd1))
				tima <= bus.wdata;        // cpu write beats the tick
			else if (tima_tick) begin
				if (tima == 8'hff) begin
					tima <= tma;              // reload
					irq  <= 1'b1;
				end else
					tima <= tima + 8'd1;
			end

			if (sel && (bus.addr[1:0] == 2'd2))
				tma <= bus.wdata;
			if (sel && (bus.addr[1:0] == 2'd3))
				tac <= bus.wdata[2:0];
		end
	end

	always_comb begin
		case (bus.addr[1:0])
			2'd0:    rdata = div_q;
			2'd1:    rdata = tima;
			2'd2:    rdata = tma;
			default: rdata = {5'b00000, tac};
		endcase
	end

endmodule

// ==== logic/gb_joypad.sv ====
/*
 * Joypad matrix at ff00, joystick bits are active high.
 * Key-press irq fires on any new press, whatever the select lines say.
 */
`timescale 1ns/1ps

module gb_joypad (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] joystick, // right left up down a b select start
	gb_bus_if.per      bus,
	output logic [7:0] rdata,
	output logic       irq
);

	logic [1:0] sel_q;    // p15 p14, low selects a group
	logic [3:0] dir_n;
	logic [3:0] btn_n;
	logic [3:0] nib;
	logic [7:0] sync1_q;
	logic [7:0] sync2_q;
	logic [7:0] prev_q;   // previous synced state for edge detect

	assign dir_n = ~joystick[3:0];
	assign btn_n = ~joystick[7:4];
	assign nib   = (sel_q[0] ? 4'hf : dir_n) & (sel_q[1] ? 4'hf : btn_n);
	assign rdata = {2'b11, sel_q, nib};

	always_ff @(posedge clk) begin
		if (reset) begin
			sel_q   <= 2'b11;
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
			irq     <= 1'b0;
		end else begin
			if (bus.wr && (bus.region == gb_map_pkg::joy))
				sel_q <= bus.wdata[5:4];
			sync1_q <= joystick;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
			irq     <= |(sync2_q & ~prev_q); // newly pressed line
		end
	end

endmodule

// ==== logic/gb_work_ram.sv ====
/*
 * Internal RAM c000-fdff (echo aliased by the address width) and
 * high RAM ff80-fffe. Read data is registered on rd and held until the
 * next ram read. No reset on the arrays.
 */
`timescale 1ns/1ps
`include "gb_config.svh"

module gb_work_ram (
	input  logic       clk,
	gb_bus_if.per      bus,
	output logic [7:0] rdata
);

	logic [7:0] iram_mem [1 << `GB_IRAM_AW];
	logic [7:0] hram_mem [(1 << `GB_HRAM_AW) - 1]; // ffff belongs to IE
	logic       iram_hit;
	logic       hram_hit;

	assign iram_hit = bus.region == gb_map_pkg::iram;
	assign hram_hit = bus.region == gb_map_pkg::hram;

	always_ff @(posedge clk) begin
		if (bus.wr && iram_hit)
			iram_mem[bus.addr[`GB_IRAM_AW-1:0]] <= bus.wdata; // e000+ lands on c000+
		if (bus.wr && hram_hit)
			hram_mem[bus.addr[`GB_HRAM_AW-1:0]] <= bus.wdata;
		if (bus.rd && iram_hit)
			rdata <= iram_mem[bus.addr[`GB_IRAM_AW-1:0]];
		else if (bus.rd && hram_hit)
			rdata <= hram_mem[bus.addr[`GB_HRAM_AW-1:0]];
	end

endmodule

// ==== logic/gb_sys.sv ====
/*
 * System-bus core top level.
 * CPU, video, audio, serial and DMA live outside; cartridge and boot ROM
 * decode cpu_addr themselves and return data on cart_data / boot_rom_data.
 */
`timescale 1ns/1ps

module gb_sys (
	input  logic        clk,
	input  logic        reset,
	input  logic        fast_boot,
	input  logic [7:0]  joystick,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_rd,
	input  logic        cpu_wr,
	input  logic        irq_ack,
	output logic [7:0]  cpu_rdata,
	output logic        irq,
	output logic        cart_rd,
	output logic        cart_wr,
	input  logic [7:0]  cart_data,
	input  logic [7:0]  boot_rom_data
);

	logic [7:0] joy_rdata;
	logic [7:0] timer_rdata;
	logic [7:0] irq_rdata;
	logic [7:0] ram_rdata;
	logic [7:0] irq_vec;
	logic       timer_irq;
	logic       joy_irq;

	gb_bus_if bus ();

	// --------------------
	// decode and read path
	gb_bus_decode u_decode (
		.clk           (clk),
		.reset         (reset),
		.fast_boot     (fast_boot),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_rd        (cpu_rd),
		.cpu_wr        (cpu_wr),
		.irq_ack       (irq_ack),
		.bus           (bus.dec),
		.joy_rdata     (joy_rdata),
		.timer_rdata   (timer_rdata),
		.irq_rdata     (irq_rdata),
		.ram_rdata     (ram_rdata),
		.cart_data     (cart_data),
		.boot_rom_data (boot_rom_data),
		.irq_vec       (irq_vec),
		.cpu_rdata     (cpu_rdata),
		.cart_rd       (cart_rd),
		.cart_wr       (cart_wr)
	);

	// --------------------
	// peripherals
	gb_irq_ctrl u_irq (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus.per),
		.irq_ack   (irq_ack),
		.timer_irq (timer_irq),
		.joy_irq   (joy_irq),
		.irq       (irq),
		.irq_vec   (irq_vec),
		.rdata     (irq_rdata)
	);

	gb_timer u_timer (
		.clk   (clk),
		.reset (reset),
		.bus   (bus.per),
		.irq   (timer_irq),
		.rdata (timer_rdata)
	);

	gb_joypad u_joy (
		.clk      (clk),
		.reset    (reset),
		.joystick (joystick),
		.bus      (bus.per),
		.rdata    (joy_rdata),
		.irq      (joy_irq)
	);

	gb_work_ram u_ram (
		.clk   (clk),
		.bus   (bus.per),
		.rdata (ram_rdata)
	);

endmodule

// ==== tests/gb_sys_tb.sv ====
/*
 * Testbench for the system-bus core.
 * Models IE, IF, joypad select, boot overlay and both RAMs; timer values
 * are checked by rule (reload, DIV clear) and not modeled cycle by cycle.
 */
`timescale 1ns/1ps
`include "gb_config.svh"

module gb_sys_tb;

	logic        clk;
	logic        reset;
	logic        fast_boot;
	logic [7:0]  joystick;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_rd;
	logic        cpu_wr;
	logic        irq_ack;
	logic [7:0]  cpu_rdata;
	logic        irq;
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_data;
	logic [7:0]  boot_rom_data;

	integer      seed = 32'hc915;
	integer      n_checks = 0;
	integer      n_mismatch = 0;
	integer      n_timeout = 0;
	logic        cart_rd_seen; // strobe captured mid-cycle
	logic        cart_wr_seen;

	// model state
	logic [4:0]  m_ie;
	logic [4:0]  m_if;
	logic [1:0]  m_sel;
	logic        m_boot;
	logic [7:0]  iram_model [1 << `GB_IRAM_AW];
	logic [7:0]  hram_model [(1 << `GB_HRAM_AW) - 1];

	gb_sys uut (
		.clk           (clk),
		.reset         (reset),
		.fast_boot     (fast_boot),
		.joystick      (joystick),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_rd        (cpu_rd),
		.cpu_wr        (cpu_wr),
		.irq_ack       (irq_ack),
		.cpu_rdata     (cpu_rdata),
		.irq           (irq),
		.cart_rd       (cart_rd),
		.cart_wr       (cart_wr),
		.cart_data     (cart_data),
		.boot_rom_data (boot_rom_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// --------------------
	// reference model
	function automatic logic [7:0] expected_read(input logic [15:0] a);
		logic [3:0] nib;
		nib = 4'hf;
		if (!m_sel[0])
			nib = nib & ~joystick[3:0]; // directions, active low
		if (!m_sel[1])
			nib = nib & ~joystick[7:4]; // buttons
		if (a < 16'h0100 && m_boot)
			return boot_rom_data;
		if (a < 16'h8000)
			return cart_data;
		if (a < 16'ha000)
			return 8'hff;               // vram lives elsewhere
		if (a < 16'hc000)
			return cart_data;
		if (a < 16'hfe00)
			return iram_model[a[`GB_IRAM_AW-1:0]];
		if (a == gb_map_pkg::ie_addr)
			return {3'b000, m_ie};
		if (a >= 16'hff80)
			return hram_model[a[`GB_HRAM_AW-1:0]];
		if (a == gb_map_pkg::joy_addr)
			return {2'b11, m_sel, nib};
		if (a == gb_map_pkg::if_addr)
			return {3'b000, m_if};
		if (a == gb_map_pkg::boot_ctl_addr)
			return (fast_boot && m_boot) ? `GB_FAST_BOOT_FLAG : 8'hff;
		return 8'hff;                   // oam, audio, video, serial
	endfunction

	// first pending enabled source from index 0 up takes the vector
	function automatic logic [7:0] expected_vector();
		logic [4:0] p;
		logic [7:0] vec;
		p = m_ie & m_if;
		vec = 8'hff;
		for (int i = 0; i < 5; i++) begin
			if (p[i] && vec == 8'hff)
				vec = 8'h40 + 8'(i * 8); // table steps by 8
		end
		return vec;
	endfunction

	function automatic void model_write(input logic [15:0] a, input logic [7:0] d);
		if (a >= 16'hc000 && a < 16'hfe00)
			iram_model[a[`GB_IRAM_AW-1:0]] = d; // echo folds onto c000
		else if (a == gb_map_pkg::ie_addr)
			m_ie = d[4:0];
		else if (a >= 16'hff80)
			hram_model[a[`GB_HRAM_AW-1:0]] = d;
		else if (a == gb_map_pkg::if_addr)
			m_if = d[4:0];
		else if (a == gb_map_pkg::joy_addr)
			m_sel = d[5:4];
		else if (a == gb_map_pkg::boot_ctl_addr && d[0])
			m_boot = 1'b0;
	endfunction

	// --------------------
	// bus tasks, entered 2 ns after an edge, one cycle each
	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		cpu_addr  = a;
		cpu_wdata = d;
		cpu_wr    = 1'b1;
		#10 cart_wr_seen = cart_wr;
		@(posedge clk);
		#2 cpu_wr = 1'b0;
		model_write(a, d);
	endtask

	task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
		cpu_addr = a;
		cpu_rd   = 1'b1;
		#10 cart_rd_seen = cart_rd;
		@(posedge clk);
		#2 cpu_rd = 1'b0;
		d = cpu_rdata;                  // registered, stable until next read
	endtask

	task automatic ack_irq(output logic [7:0] v);
		irq_ack = 1'b1;
		@(posedge clk);
		#2 irq_ack = 1'b0;
		v = cpu_rdata;
	endtask

	task automatic compare_byte(input string what, input logic [7:0] got,
			input logic [7:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_mismatch++;
			$display("FAILED %s: got %h expected %h at %0t", what, got, exp, $time);
		end
	endtask

	task automatic check_read(input logic [15:0] a);
		logic [7:0] exp;
		logic [7:0] d;
		exp = expected_read(a);
		bus_read(a, d);
		compare_byte($sformatf("cpu_rdata @%h", a), d, exp);
	endtask

	// polls a flag in IF, gives up after max_reads
	task automatic wait_if_bit(input int bit_idx, input int max_reads, output logic got);
		logic [7:0] d;
		got = 1'b0;
		for (int k = 0; k < max_reads && !got; k++) begin
			bus_read(gb_map_pkg::if_addr, d);
			got = d[bit_idx];
		end
	endtask

	// --------------------
	// stimulus
	initial begin
		logic [15:0] a;
		logic [7:0]  d;
		logic [7:0]  v;
		logic        got;
		logic [15:0] written [$];
		logic [15:0] edges [6];
		logic [15:0] dead [7];

		edges = '{16'hc000, 16'hdfff, 16'he000, 16'hfdff, 16'hff80, 16'hfffe};
		dead = '{16'h8000, 16'h9fff, 16'hfe00, 16'hff01, 16'hff10, 16'hff40,
			16'hff7f};
		reset = 1'b1;
		fast_boot = 1'b1;
		joystick = 8'h00;
		cpu_addr = 16'h0000;
		cpu_wdata = 8'h00;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		irq_ack = 1'b0;
		cart_data = 8'h00;
		boot_rom_data = 8'h00;
		m_ie = '0;
		m_if = '0;
		m_sel = 2'b11;
		m_boot = 1'b1;
		repeat (16) @(posedge clk);
		#2 reset = 1'b0;

		// idle values after reset
		compare_byte("cpu_rdata after reset", cpu_rdata, 8'hff);
		compare_byte("irq after reset", {7'd0, irq}, 8'h00);
		foreach (dead[i])
			check_read(dead[i]);

		// RAMs, random fill then read back
		repeat (40) begin
			if ($random(seed) & 1)
				a = 16'hc000 + 16'({$random(seed)} % 32'h3e00);
			else
				a = 16'hff80 + 16'({$random(seed)} % 127);
			bus_write(a, 8'($random(seed)));
			written.push_back(a);
		end
		foreach (edges[i]) begin
			bus_write(edges[i], 8'($random(seed)));
			written.push_back(edges[i]);
		end
		bus_write(16'hc123, 8'($random(seed)));
		check_read(16'he123);           // echo alias
		bus_write(16'hfd00, 8'($random(seed)));
		check_read(16'hdd00);
		foreach (written[i])
			check_read(written[i]);

		// boot overlay and cartridge strobes
		boot_rom_data = 8'($random(seed));
		cart_data = 8'($random(seed));
		check_read(16'h0050);
		compare_byte("cart_rd under overlay", {7'd0, cart_rd_seen}, 8'h00);
		check_read(gb_map_pkg::boot_ctl_addr); // fast boot flag
		bus_write(16'h2000, 8'h01);
		compare_byte("cart_wr", {7'd0, cart_wr_seen}, 8'h01);
		bus_write(gb_map_pkg::boot_ctl_addr, 8'h01);
		check_read(16'h0050);
		compare_byte("cart_rd after overlay", {7'd0, cart_rd_seen}, 8'h01);
		check_read(gb_map_pkg::boot_ctl_addr);
		check_read(16'ha123);

		// interrupt priority, first round with everything pending
		for (int r = 0; r < 6; r++) begin
			bus_write(gb_map_pkg::if_addr, (r == 0) ? 8'h1f : 8'($random(seed)));
			bus_write(gb_map_pkg::ie_addr, (r == 0) ? 8'h1f : 8'($random(seed)));
			check_read(gb_map_pkg::ie_addr);
			for (int k = 0; k < 6 && (m_ie & m_if) != 0; k++) begin
				compare_byte("irq", {7'd0, irq}, 8'h01);
				d = expected_vector();
				ack_irq(v);
				compare_byte("irq vector", v, d);
				m_if[(d - 8'h40) >> 3] = 1'b0;
				check_read(gb_map_pkg::if_addr);
			end
			compare_byte("irq when idle", {7'd0, irq}, 8'h00);
		end

		// joypad select and key press
		joystick = 8'($random(seed)) & 8'h7f; // start stays released
		for (int s = 0; s < 4; s++) begin
			bus_write(gb_map_pkg::joy_addr, {2'b00, 2'(s), 4'h0});
			check_read(gb_map_pkg::joy_addr);
		end
		bus_write(gb_map_pkg::if_addr, 8'h00); // press edges above have settled
		joystick[7] = 1'b1;
		wait_if_bit(4, 20, got);
		if (!got) begin
			n_timeout++;
			$display("ERROR: IF bit 4 never set after a key press");
		end
		m_if[4] = 1'b1;
		check_read(gb_map_pkg::if_addr);

		// timer overflow and reload
		bus_write(16'hff06, 8'hf0);
		bus_write(16'hff05, 8'hf0);
		bus_write(gb_map_pkg::if_addr, 8'h00);
		bus_write(16'hff07, 8'h05); // enabled, 16 clocks per tick
		wait_if_bit(2, 1000, got);
		if (!got) begin
			n_timeout++;
			$display("ERROR: timer overflow never raised IF bit 2");
		end
		bus_read(16'hff05, d);
		n_checks++;
		if (d < 8'hf0) begin
			n_mismatch++;
			$display("FAILED TIMA: got %h expected at least f0", d);
		end
		bus_write(16'hff07, 8'h00);
		m_if[2] = 1'b1;
		check_read(gb_map_pkg::if_addr);
		bus_write(16'hff04, 8'h5a);
		bus_read(16'hff04, d);
		compare_byte("DIV", d, 8'h00);

		$display("checks %0d, mismatches %0d, timeouts %0d", n_checks, n_mismatch,
			n_timeout);
		if (n_mismatch == 0 && n_timeout == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+include
logic/gb_map_pkg.sv
logic/gb_periph_pkg.sv
logic/gb_bus_if.sv
logic/gb_bus_decode.sv
logic/gb_irq_ctrl.sv
logic/gb_timer.sv
logic/gb_joypad.sv
logic/gb_work_ram.sv
logic/gb_sys.sv
tests/gb_sys_tb.sv

// ==== Bender.yml ====
package:
  name: gb_sys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/gb_map_pkg.sv
      - logic/gb_periph_pkg.sv
      - logic/gb_bus_if.sv
      - logic/gb_bus_decode.sv
      - logic/gb_irq_ctrl.sv
      - logic/gb_timer.sv
      - logic/gb_joypad.sv
      - logic/gb_work_ram.sv
      - logic/gb_sys.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/gb_sys_tb.sv
